// ==== mips_consts.svh ====
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// Data path width
`define WORD_W 32

// General register addressing
`define REG_ADDR_W 5
`define REG_COUNT 32

`define ZERO_WORD 32'h0000_0000

`endif

// ==== mips_pkg.sv ====
package mips_pkg;

	// Primary opcode field, inst[31:26]
	typedef enum logic [5:0]
	{
		op_special = 6'd0,
		op_addiu   = 6'd9,
		op_slti    = 6'd10,
		op_sltiu   = 6'd11,
		op_andi    = 6'd12,
		op_ori     = 6'd13,
		op_xori    = 6'd14,
		op_lui     = 6'd15
	} opcode_t;

	// Function field of special opcode, inst[5:0]
	typedef enum logic [5:0]
	{
		fn_addu = 6'h21,
		fn_subu = 6'h23,
		fn_and  = 6'h24,
		fn_or   = 6'h25,
		fn_xor  = 6'h26,
		fn_slt  = 6'h2a,
		fn_sltu = 6'h2b
	} funct_t;

	typedef enum logic [3:0]
	{
		alu_nop,
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,
		alu_sltu,
		alu_lui
	} alu_op_t;

endpackage

// ==== gpr_file.sv ====
`timescale 1ns/1ps
`include "mips_consts.svh"

module gpr_file(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   we1,
	input  logic                   we2,
	input  logic [`REG_ADDR_W-1:0] waddr1,
	input  logic [`REG_ADDR_W-1:0] waddr2,
	input  logic [`WORD_W-1:0]     wdata1,
	input  logic [`WORD_W-1:0]     wdata2,
	input  logic [`REG_ADDR_W-1:0] raddr1,
	input  logic [`REG_ADDR_W-1:0] raddr2,
	input  logic [`REG_ADDR_W-1:0] raddr3,
	input  logic [`REG_ADDR_W-1:0] raddr4,
	output logic [`WORD_W-1:0]     rdata1,
	output logic [`WORD_W-1:0]     rdata2,
	output logic [`WORD_W-1:0]     rdata3,
	output logic [`WORD_W-1:0]     rdata4
);

logic [`WORD_W-1:0] regs [`REG_COUNT];
logic [`REG_ADDR_W-1:0] raddr_v [4];
logic [`WORD_W-1:0] rdata_v [4];

// Later assignment wins, so port 2 takes a conflicting write
always_ff @(posedge clk)
begin
	if (!rst_n)
	begin
		regs <= '{default: `ZERO_WORD};
	end else begin
		if (we1 && waddr1 != '0)
			regs[waddr1] <= wdata1;
		if (we2 && waddr2 != '0)
			regs[waddr2] <= wdata2;
	end
end

assign raddr_v[0] = raddr1;
assign raddr_v[1] = raddr2;
assign raddr_v[2] = raddr3;
assign raddr_v[3] = raddr4;

for (genvar i = 0; i < 4; i++)
begin : g_read
	always_comb
	begin
		if (raddr_v[i] == '0)
			rdata_v[i] = `ZERO_WORD;
		else if (we2 && waddr2 == raddr_v[i])
			rdata_v[i] = wdata2;
		else if (we1 && waddr1 == raddr_v[i])
			rdata_v[i] = wdata1;
		else
			rdata_v[i] = regs[raddr_v[i]];
	end
end

assign rdata1 = rdata_v[0];
assign rdata2 = rdata_v[1];
assign rdata3 = rdata_v[2];
assign rdata4 = rdata_v[3];

endmodule

// ==== inst_decode.sv ====
`timescale 1ns/1ps
`include "mips_consts.svh"

module inst_decode(
	input  logic [`WORD_W-1:0]     inst,
	input  logic                   valid,
	output logic [`REG_ADDR_W-1:0] raddr1,
	output logic [`REG_ADDR_W-1:0] raddr2,
	input  logic [`WORD_W-1:0]     rdata1,
	input  logic [`WORD_W-1:0]     rdata2,
	input  logic                   ex_we_a,
	input  logic                   ex_we_b,
	input  logic [`REG_ADDR_W-1:0] ex_waddr_a,
	input  logic [`REG_ADDR_W-1:0] ex_waddr_b,
	input  logic [`WORD_W-1:0]     ex_wdata_a,
	input  logic [`WORD_W-1:0]     ex_wdata_b,
	output mips_pkg::alu_op_t      alu_op,
	output logic [`WORD_W-1:0]     opnd1,
	output logic [`WORD_W-1:0]     opnd2,
	output logic                   we,
	output logic [`REG_ADDR_W-1:0] waddr
);

logic [5:0] opcode, funct;
logic [`REG_ADDR_W-1:0] rs, rt, rd;
logic [15:0] imm;
logic [`WORD_W-1:0] imm_ext;
logic [`WORD_W-1:0] fwd_rs, fwd_rt;
logic is_rtype, sign_ext;

assign opcode = inst[31:26];
assign rs     = inst[25:21];
assign rt     = inst[20:16];
assign rd     = inst[15:11];
assign imm    = inst[15:0];
assign funct  = inst[5:0];

assign raddr1 = rs;
assign raddr2 = rt;

// Lane b's EX result is younger, so it is checked first
function automatic logic [`WORD_W-1:0] forward(
	input logic [`REG_ADDR_W-1:0] addr,
	input logic [`WORD_W-1:0]     rf_data
);
	if (addr == '0)
		return `ZERO_WORD;
	else if (ex_we_b && ex_waddr_b == addr)
		return ex_wdata_b;
	else if (ex_we_a && ex_waddr_a == addr)
		return ex_wdata_a;
	else
		return rf_data;
endfunction

always_comb
begin
	alu_op   = mips_pkg::alu_nop;
	is_rtype = 1'b0;
	sign_ext = 1'b0;
	case (opcode)
		mips_pkg::op_special:
		begin
			is_rtype = 1'b1;
			case (funct)
				mips_pkg::fn_addu: alu_op = mips_pkg::alu_add;
				mips_pkg::fn_subu: alu_op = mips_pkg::alu_sub;
				mips_pkg::fn_and:  alu_op = mips_pkg::alu_and;
				mips_pkg::fn_or:   alu_op = mips_pkg::alu_or;
				mips_pkg::fn_xor:  alu_op = mips_pkg::alu_xor;
				mips_pkg::fn_slt:  alu_op = mips_pkg::alu_slt;
				mips_pkg::fn_sltu: alu_op = mips_pkg::alu_sltu;
				default:           alu_op = mips_pkg::alu_nop;
			endcase
		end
		mips_pkg::op_addiu:
		begin
			alu_op   = mips_pkg::alu_add;
			sign_ext = 1'b1;
		end
		mips_pkg::op_slti:
		begin
			alu_op   = mips_pkg::alu_slt;
			sign_ext = 1'b1;
		end
		mips_pkg::op_sltiu:
		begin
			alu_op   = mips_pkg::alu_sltu;
			sign_ext = 1'b1;
		end
		mips_pkg::op_andi: alu_op = mips_pkg::alu_and;
		mips_pkg::op_ori:  alu_op = mips_pkg::alu_or;
		mips_pkg::op_xori: alu_op = mips_pkg::alu_xor;
		mips_pkg::op_lui:  alu_op = mips_pkg::alu_lui;
		default:           alu_op = mips_pkg::alu_nop;
	endcase
end

assign imm_ext = sign_ext ? {{16{imm[15]}}, imm} : {16'h0000, imm};

always_comb
begin
	fwd_rs = forward(rs, rdata1);
	fwd_rt = forward(rt, rdata2);
end

assign opnd1 = fwd_rs;
assign opnd2 = is_rtype ? fwd_rt : imm_ext;

assign waddr = is_rtype ? rd : rt;
assign we    = valid && alu_op != mips_pkg::alu_nop && waddr != '0;

endmodule

// ==== issue_pair_ctrl.sv ====
`timescale 1ns/1ps
`include "mips_consts.svh"

module issue_pair_ctrl(
	input  logic               inst_valid,
	input  logic [`WORD_W-1:0] inst_a,
	input  logic [`WORD_W-1:0] inst_b,
	output logic               inst_b_taken
);

logic [`REG_ADDR_W-1:0] dest_a;
logic a_writes;
logic b_reads_rs, b_reads_rt;
logic conflict;

function automatic logic is_alu_funct(input logic [5:0] funct);
	case (funct)
		mips_pkg::fn_addu, mips_pkg::fn_subu, mips_pkg::fn_and, mips_pkg::fn_or,
		mips_pkg::fn_xor, mips_pkg::fn_slt, mips_pkg::fn_sltu: return 1'b1;
		default: return 1'b0;
	endcase
endfunction

function automatic logic is_alu_imm(input logic [5:0] opcode);
	return opcode >= mips_pkg::op_addiu && opcode <= mips_pkg::op_lui;
endfunction

always_comb
begin
	a_writes = 1'b0;
	dest_a   = inst_a[20:16];
	if (inst_a[31:26] == mips_pkg::op_special)
	begin
		a_writes = is_alu_funct(inst_a[5:0]);
		dest_a   = inst_a[15:11];
	end else begin
		a_writes = is_alu_imm(inst_a[31:26]);
	end
end

always_comb
begin
	b_reads_rt = inst_b[31:26] == mips_pkg::op_special && is_alu_funct(inst_b[5:0]);
	// lui ignores its rs field
	b_reads_rs = b_reads_rt ||
		(is_alu_imm(inst_b[31:26]) && inst_b[31:26] != mips_pkg::op_lui);
end

assign conflict = a_writes && dest_a != '0 &&
	((b_reads_rs && inst_b[25:21] == dest_a) || (b_reads_rt && inst_b[20:16] == dest_a));

assign inst_b_taken = inst_valid && !conflict;

endmodule

// ==== id_ex_regs.sv ====
`timescale 1ns/1ps
`include "mips_consts.svh"

module id_ex_regs(
	input  logic                   clk,
	input  logic                   rst_n,
	input  mips_pkg::alu_op_t      in_op_a,
	input  logic [`WORD_W-1:0]     in_opnd1_a,
	input  logic [`WORD_W-1:0]     in_opnd2_a,
	input  logic                   in_we_a,
	input  logic [`REG_ADDR_W-1:0] in_waddr_a,
	input  mips_pkg::alu_op_t      in_op_b,
	input  logic [`WORD_W-1:0]     in_opnd1_b,
	input  logic [`WORD_W-1:0]     in_opnd2_b,
	input  logic                   in_we_b,
	input  logic [`REG_ADDR_W-1:0] in_waddr_b,
	output mips_pkg::alu_op_t      op_a,
	output logic [`WORD_W-1:0]     opnd1_a,
	output logic [`WORD_W-1:0]     opnd2_a,
	output logic                   we_a,
	output logic [`REG_ADDR_W-1:0] waddr_a,
	output mips_pkg::alu_op_t      op_b,
	output logic [`WORD_W-1:0]     opnd1_b,
	output logic [`WORD_W-1:0]     opnd2_b,
	output logic                   we_b,
	output logic [`REG_ADDR_W-1:0] waddr_b
);

// Control fields
always_ff @(posedge clk)
begin
	if (!rst_n)
	begin
		op_a <= mips_pkg::alu_nop;
		op_b <= mips_pkg::alu_nop;
		we_a <= 1'b0;
		we_b <= 1'b0;
	end else begin
		op_a <= in_op_a;
		op_b <= in_op_b;
		we_a <= in_we_a;
		we_b <= in_we_b;
	end
end

// Operands and destinations
always_ff @(posedge clk)
begin
	opnd1_a <= in_opnd1_a;
	opnd2_a <= in_opnd2_a;
	waddr_a <= in_waddr_a;
	opnd1_b <= in_opnd1_b;
	opnd2_b <= in_opnd2_b;
	waddr_b <= in_waddr_b;
end

endmodule

// ==== alu_lane.sv ====
`timescale 1ns/1ps
`include "mips_consts.svh"

module alu_lane(
	input  logic                   clk,
	input  logic                   rst_n,
	input  mips_pkg::alu_op_t      op,
	input  logic [`WORD_W-1:0]     opnd1,
	input  logic [`WORD_W-1:0]     opnd2,
	input  logic                   we,
	input  logic [`REG_ADDR_W-1:0] waddr,
	output logic [`WORD_W-1:0]     ex_result,
	output logic                   wb_we,
	output logic [`REG_ADDR_W-1:0] wb_waddr,
	output logic [`WORD_W-1:0]     wb_wdata
);

logic signed_lt, unsigned_lt;

assign signed_lt   = $signed(opnd1) < $signed(opnd2);
assign unsigned_lt = opnd1 < opnd2;

always_comb
begin
	case (op)
		mips_pkg::alu_add:  ex_result = opnd1 + opnd2;
		mips_pkg::alu_sub:  ex_result = opnd1 - opnd2;
		mips_pkg::alu_and:  ex_result = opnd1 & opnd2;
		mips_pkg::alu_or:   ex_result = opnd1 | opnd2;
		mips_pkg::alu_xor:  ex_result = opnd1 ^ opnd2;
		mips_pkg::alu_slt:  ex_result = {{(`WORD_W-1){1'b0}}, signed_lt};
		mips_pkg::alu_sltu: ex_result = {{(`WORD_W-1){1'b0}}, unsigned_lt};
		// Immediate arrives zero-extended in opnd2
		mips_pkg::alu_lui:  ex_result = {opnd2[15:0], 16'h0000};
		default:            ex_result = `ZERO_WORD;
	endcase
end

always_ff @(posedge clk)
begin
	if (!rst_n)
		wb_we <= 1'b0;
	else
		wb_we <= we;
end

always_ff @(posedge clk)
begin
	wb_waddr <= waddr;
	wb_wdata <= ex_result;
end

endmodule

// ==== dual_issue_core.sv ====
`timescale 1ns/1ps
`include "mips_consts.svh"

module dual_issue_core(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   inst_valid,
	input  logic [`WORD_W-1:0]     inst_a,
	input  logic [`WORD_W-1:0]     inst_b,
	output logic                   inst_b_taken,
	output logic                   wb_we_a,
	output logic [`REG_ADDR_W-1:0] wb_waddr_a,
	output logic [`WORD_W-1:0]     wb_wdata_a,
	output logic                   wb_we_b,
	output logic [`REG_ADDR_W-1:0] wb_waddr_b,
	output logic [`WORD_W-1:0]     wb_wdata_b
);

logic [`REG_ADDR_W-1:0] reg_raddr1, reg_raddr2, reg_raddr3, reg_raddr4;
logic [`WORD_W-1:0]     reg_rdata1, reg_rdata2, reg_rdata3, reg_rdata4;

mips_pkg::alu_op_t      id_op_a, id_op_b;
logic [`WORD_W-1:0]     id_opnd1_a, id_opnd2_a, id_opnd1_b, id_opnd2_b;
logic                   id_we_a, id_we_b;
logic [`REG_ADDR_W-1:0] id_waddr_a, id_waddr_b;

mips_pkg::alu_op_t      ex_op_a, ex_op_b;
logic [`WORD_W-1:0]     ex_opnd1_a, ex_opnd2_a, ex_opnd1_b, ex_opnd2_b;
logic                   ex_we_a, ex_we_b;
logic [`REG_ADDR_W-1:0] ex_waddr_a, ex_waddr_b;
logic [`WORD_W-1:0]     ex_result_a, ex_result_b;

// Port 2 carries lane b so the younger write wins
gpr_file u_gpr(
	.clk,
	.rst_n,
	.we1(wb_we_a),
	.we2(wb_we_b),
	.waddr1(wb_waddr_a),
	.waddr2(wb_waddr_b),
	.wdata1(wb_wdata_a),
	.wdata2(wb_wdata_b),
	.raddr1(reg_raddr1),
	.raddr2(reg_raddr2),
	.raddr3(reg_raddr3),
	.raddr4(reg_raddr4),
	.rdata1(reg_rdata1),
	.rdata2(reg_rdata2),
	.rdata3(reg_rdata3),
	.rdata4(reg_rdata4)
);

issue_pair_ctrl u_issue(
	.inst_valid,
	.inst_a,
	.inst_b,
	.inst_b_taken
);

inst_decode u_dec_a(
	.inst(inst_a),
	.valid(inst_valid),
	.raddr1(reg_raddr1),
	.raddr2(reg_raddr2),
	.rdata1(reg_rdata1),
	.rdata2(reg_rdata2),
	.ex_we_a,
	.ex_we_b,
	.ex_waddr_a,
	.ex_waddr_b,
	.ex_wdata_a(ex_result_a),
	.ex_wdata_b(ex_result_b),
	.alu_op(id_op_a),
	.opnd1(id_opnd1_a),
	.opnd2(id_opnd2_a),
	.we(id_we_a),
	.waddr(id_waddr_a)
);

// A lane b that is not taken goes down as a bubble
inst_decode u_dec_b(
	.inst(inst_b),
	.valid(inst_valid & inst_b_taken),
	.raddr1(reg_raddr3),
	.raddr2(reg_raddr4),
	.rdata1(reg_rdata3),
	.rdata2(reg_rdata4),
	.ex_we_a,
	.ex_we_b,
	.ex_waddr_a,
	.ex_waddr_b,
	.ex_wdata_a(ex_result_a),
	.ex_wdata_b(ex_result_b),
	.alu_op(id_op_b),
	.opnd1(id_opnd1_b),
	.opnd2(id_opnd2_b),
	.we(id_we_b),
	.waddr(id_waddr_b)
);

id_ex_regs u_id_ex(
	.clk,
	.rst_n,
	.in_op_a(id_op_a),
	.in_opnd1_a(id_opnd1_a),
	.in_opnd2_a(id_opnd2_a),
	.in_we_a(id_we_a),
	.in_waddr_a(id_waddr_a),
	.in_op_b(id_op_b),
	.in_opnd1_b(id_opnd1_b),
	.in_opnd2_b(id_opnd2_b),
	.in_we_b(id_we_b),
	.in_waddr_b(id_waddr_b),
	.op_a(ex_op_a),
	.opnd1_a(ex_opnd1_a),
	.opnd2_a(ex_opnd2_a),
	.we_a(ex_we_a),
	.waddr_a(ex_waddr_a),
	.op_b(ex_op_b),
	.opnd1_b(ex_opnd1_b),
	.opnd2_b(ex_opnd2_b),
	.we_b(ex_we_b),
	.waddr_b(ex_waddr_b)
);

alu_lane u_alu_a(
	.clk,
	.rst_n,
	.op(ex_op_a),
	.opnd1(ex_opnd1_a),
	.opnd2(ex_opnd2_a),
	.we(ex_we_a),
	.waddr(ex_waddr_a),
	.ex_result(ex_result_a),
	.wb_we(wb_we_a),
	.wb_waddr(wb_waddr_a),
	.wb_wdata(wb_wdata_a)
);

alu_lane u_alu_b(
	.clk,
	.rst_n,
	.op(ex_op_b),
	.opnd1(ex_opnd1_b),
	.opnd2(ex_opnd2_b),
	.we(ex_we_b),
	.waddr(ex_waddr_b),
	.ex_result(ex_result_b),
	.wb_we(wb_we_b),
	.wb_waddr(wb_waddr_b),
	.wb_wdata(wb_wdata_b)
);

endmodule

// ==== dual_issue_core_props.sv ====
`timescale 1ns/1ps
`include "mips_consts.svh"

module dual_issue_core_props(
	input logic                   clk,
	input logic                   rst_n,
	input logic                   inst_valid,
	input logic                   inst_b_taken,
	input logic                   wb_we_a,
	input logic [`REG_ADDR_W-1:0] wb_waddr_a,
	input logic                   wb_we_b,
	input logic [`REG_ADDR_W-1:0] wb_waddr_b
);

int fail_count = 0;

// Register zero is never a write target
no_r0_write_a: assert property (@(posedge clk) disable iff (!rst_n)
	wb_we_a |-> wb_waddr_a != '0)
	else
	begin
		fail_count++;
		$error("lane a writes register zero");
	end

no_r0_write_b: assert property (@(posedge clk) disable iff (!rst_n)
	wb_we_b |-> wb_waddr_b != '0)
	else
	begin
		fail_count++;
		$error("lane b writes register zero");
	end

taken_needs_valid: assert property (@(posedge clk) !inst_valid |-> !inst_b_taken)
	else
	begin
		fail_count++;
		$error("inst_b_taken high without inst_valid");
	end

// Synchronous reset, so enables are cleared one edge later
reset_clears_wb: assert property (@(posedge clk) !rst_n |=> !wb_we_a && !wb_we_b)
	else
	begin
		fail_count++;
		$error("writeback enable high during reset");
	end

endmodule

bind dual_issue_core dual_issue_core_props u_props(
	.clk(clk),
	.rst_n(rst_n),
	.inst_valid(inst_valid),
	.inst_b_taken(inst_b_taken),
	.wb_we_a(wb_we_a),
	.wb_waddr_a(wb_waddr_a),
	.wb_we_b(wb_we_b),
	.wb_waddr_b(wb_waddr_b)
);

// ==== dual_issue_core_tb.sv ====
`timescale 1ns/1ps
`include "mips_consts.svh"

module dual_issue_core_tb;

typedef struct {
	int                     due;
	logic                   we_a;
	logic [`REG_ADDR_W-1:0] waddr_a;
	logic [`WORD_W-1:0]     wdata_a;
	logic                   we_b;
	logic [`REG_ADDR_W-1:0] waddr_b;
	logic [`WORD_W-1:0]     wdata_b;
} wb_exp_t;

logic clk = 1'b0;
logic rst_n;
logic inst_valid;
logic [`WORD_W-1:0] inst_a, inst_b;
logic inst_b_taken;
logic wb_we_a, wb_we_b;
logic [`REG_ADDR_W-1:0] wb_waddr_a, wb_waddr_b;
logic [`WORD_W-1:0] wb_wdata_a, wb_wdata_b;

logic [`WORD_W-1:0] model_regs [`REG_COUNT];
wb_exp_t exp_q[$];
logic [31:0] lfsr = 32'd48;
int cycle = 0;
int checks = 0;
int errors = 0;

dual_issue_core u_dut(
	.clk, .rst_n, .inst_valid, .inst_a, .inst_b, .inst_b_taken,
	.wb_we_a, .wb_waddr_a, .wb_wdata_a, .wb_we_b, .wb_waddr_b, .wb_wdata_b
);

always #4 clk = ~clk;

always @(posedge clk)
	cycle <= cycle + 1;

// Galois form of x^32+x^22+x^2+x+1
function automatic logic lfsr_bit();
	logic out;
	out = lfsr[0];
	lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
	return out;
endfunction

function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] v;
	v = '0;
	for (int k = 0; k < n; k++)
		v = {v[30:0], lfsr_bit()};
	return v;
endfunction

function automatic logic [31:0] enc_r(input logic [5:0] fn, input logic [4:0] rd,
	input logic [4:0] rs, input logic [4:0] rt);
	return {6'd0, rs, rt, rd, 5'd0, fn};
endfunction

function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rt,
	input logic [4:0] rs, input logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

function automatic logic is_supported(input logic [31:0] inst);
	if (inst[31:26] == 6'd0)
		return inst[5:0] inside {6'h21, 6'h23, 6'h24, 6'h25, 6'h26, 6'h2a, 6'h2b};
	return inst[31:26] inside {[6'd9:6'd15]};
endfunction

// Expected inst_b_taken from the pairing rule
function automatic logic ref_taken(input logic [31:0] a, input logic [31:0] b);
	logic [4:0] dst;
	logic b_rs, b_rt;
	dst = (a[31:26] == 6'd0) ? a[15:11] : a[20:16];
	b_rt = is_supported(b) && b[31:26] == 6'd0;
	b_rs = is_supported(b) && b[31:26] != 6'd15;
	return !(is_supported(a) && dst != 5'd0 &&
		((b_rs && b[25:21] == dst) || (b_rt && b[20:16] == dst)));
endfunction

// One instruction against the model register file
function automatic void ref_exec(input logic [31:0] inst, output logic we,
	output logic [4:0] waddr, output logic [31:0] wdata);
	logic [31:0] s, t, simm, zimm;
	s = model_regs[inst[25:21]];
	t = model_regs[inst[20:16]];
	simm = {{16{inst[15]}}, inst[15:0]};
	zimm = {16'h0000, inst[15:0]};
	we = 1'b1;
	waddr = inst[20:16];
	wdata = '0;
	case (inst[31:26])
		mips_pkg::op_special:
		begin
			waddr = inst[15:11];
			case (inst[5:0])
				mips_pkg::fn_addu: wdata = s + t;
				mips_pkg::fn_subu: wdata = s - t;
				mips_pkg::fn_and:  wdata = s & t;
				mips_pkg::fn_or:   wdata = s | t;
				mips_pkg::fn_xor:  wdata = s ^ t;
				mips_pkg::fn_slt:  wdata = ($signed(s) < $signed(t)) ? 32'd1 : 32'd0;
				mips_pkg::fn_sltu: wdata = (s < t) ? 32'd1 : 32'd0;
				default:           we = 1'b0;
			endcase
		end
		mips_pkg::op_addiu: wdata = s + simm;
		mips_pkg::op_slti:  wdata = ($signed(s) < $signed(simm)) ? 32'd1 : 32'd0;
		mips_pkg::op_sltiu: wdata = (s < simm) ? 32'd1 : 32'd0;
		mips_pkg::op_andi:  wdata = s & zimm;
		mips_pkg::op_ori:   wdata = s | zimm;
		mips_pkg::op_xori:  wdata = s ^ zimm;
		mips_pkg::op_lui:   wdata = {inst[15:0], 16'h0000};
		default:            we = 1'b0;
	endcase
	if (waddr == 5'd0)
		we = 1'b0;
endfunction

// Registers r0 to r7 only, so hazards come often
function automatic logic [31:0] gen_inst();
	logic [3:0] sel;
	logic [4:0] rs, rt, rd;
	logic [15:0] imm;
	sel = rand_bits(4);
	rs = rand_bits(3);
	rt = rand_bits(3);
	rd = rand_bits(3);
	imm = rand_bits(16);
	case (sel)
		0: return enc_r(mips_pkg::fn_addu, rd, rs, rt);
		1: return enc_r(mips_pkg::fn_subu, rd, rs, rt);
		2: return enc_r(mips_pkg::fn_and, rd, rs, rt);
		3: return enc_r(mips_pkg::fn_or, rd, rs, rt);
		4: return enc_r(mips_pkg::fn_xor, rd, rs, rt);
		5: return enc_r(mips_pkg::fn_slt, rd, rs, rt);
		6: return enc_r(mips_pkg::fn_sltu, rd, rs, rt);
		14: return 32'h0000_0000;
		15: return enc_r(6'h20, rd, rs, rt);
		default: return enc_i(6'd9 + 6'(sel - 4'd7), rt, rs, imm);
	endcase
endfunction

task automatic check_field(input string name, input logic [31:0] got, input logic [31:0] exp);
	checks++;
	assert (got === exp)
	else
	begin
		errors++;
		$display("CHECK FAILED at %0d ns: %s got %h expected %h", $time, name, got, exp);
	end
endtask

task automatic send_pair(input logic [31:0] a, input logic [31:0] b, output logic taken);
	wb_exp_t e;
	@(posedge clk);
	inst_valid <= 1'b1;
	inst_a <= a;
	inst_b <= b;
	@(negedge clk);
	taken = ref_taken(a, b);
	check_field("inst_b_taken", inst_b_taken, taken);
	ref_exec(a, e.we_a, e.waddr_a, e.wdata_a);
	e.we_b = 1'b0;
	if (taken)
		ref_exec(b, e.we_b, e.waddr_b, e.wdata_b);
	// Lane b applied last so it wins a shared destination
	if (e.we_a)
		model_regs[e.waddr_a] = e.wdata_a;
	if (e.we_b)
		model_regs[e.waddr_b] = e.wdata_b;
	e.due = cycle + 2;
	exp_q.push_back(e);
endtask

// A refused inst_b comes back as the next inst_a
task automatic send_retry(input logic [31:0] a, input logic [31:0] b);
	logic taken;
	send_pair(a, b, taken);
	if (!taken)
		send_pair(b, 32'h0000_0000, taken);
endtask

task automatic drain();
	int waited;
	@(posedge clk);
	inst_valid <= 1'b0;
	inst_a <= '0;
	inst_b <= '0;
	waited = 0;
	while (exp_q.size() > 0 && waited < 20)
	begin
		@(negedge clk);
		waited++;
	end
	if (exp_q.size() > 0)
	begin
		errors++;
		$display("Timeout: %0d expected writebacks never appeared", exp_q.size());
		exp_q.delete();
	end
endtask

task automatic report_test(input int num, input string name, input int err_start);
	if (errors == err_start)
		$display("test %0d %s: ok", num, name);
	else
		$display("test %0d %s: %0d errors", num, name, errors - err_start);
endtask

// Writeback ports against the expected queue
always @(negedge clk)
begin
	wb_exp_t e;
	if (rst_n)
	begin
		if (exp_q.size() > 0 && exp_q[0].due == cycle)
		begin
			e = exp_q.pop_front();
			check_field("wb_we_a", wb_we_a, e.we_a);
			check_field("wb_we_b", wb_we_b, e.we_b);
			if (e.we_a)
			begin
				check_field("wb_waddr_a", wb_waddr_a, e.waddr_a);
				check_field("wb_wdata_a", wb_wdata_a, e.wdata_a);
			end
			if (e.we_b)
			begin
				check_field("wb_waddr_b", wb_waddr_b, e.waddr_b);
				check_field("wb_wdata_b", wb_wdata_b, e.wdata_b);
			end
		end else begin
			check_field("wb_we_a", wb_we_a, 1'b0);
			check_field("wb_we_b", wb_we_b, 1'b0);
		end
	end
end

initial
begin
	int err_start;
	logic [31:0] a, pend;
	logic pend_valid, taken;
	rst_n = 1'b0;
	inst_valid = 1'b0;
	inst_a = '0;
	inst_b = '0;
	for (int r = 0; r < `REG_COUNT; r++)
		model_regs[r] = `ZERO_WORD;
	repeat (10) @(posedge clk);
	rst_n <= 1'b1;

	err_start = errors;
	for (int k = 0; k < 8; k++)
	begin
		@(negedge clk);
		check_field("inst_b_taken", inst_b_taken, 1'b0);
	end
	report_test(1, "idle after reset", err_start);

	// Mixed-sign operands r1..r4
	err_start = errors;
	send_retry(enc_i(mips_pkg::op_lui, 1, 0, 16'h8000), enc_i(mips_pkg::op_lui, 2, 0, 16'h7fff));
	send_retry(enc_i(mips_pkg::op_ori, 1, 1, 16'h0001), enc_i(mips_pkg::op_ori, 2, 2, 16'hffff));
	send_retry(enc_i(mips_pkg::op_addiu, 3, 0, 16'hffff), enc_i(mips_pkg::op_addiu, 4, 0, 16'h5));
	send_retry(enc_r(mips_pkg::fn_addu, 5, 2, 4), enc_r(mips_pkg::fn_addu, 6, 3, 4));
	send_retry(enc_r(mips_pkg::fn_subu, 7, 4, 3), enc_r(mips_pkg::fn_subu, 8, 4, 2));
	send_retry(enc_r(mips_pkg::fn_and, 9, 1, 3), enc_r(mips_pkg::fn_or, 10, 1, 2));
	send_retry(enc_r(mips_pkg::fn_xor, 11, 1, 2), enc_r(mips_pkg::fn_slt, 12, 1, 2));
	send_retry(enc_r(mips_pkg::fn_sltu, 13, 1, 2), enc_r(mips_pkg::fn_slt, 14, 3, 4));
	send_retry(enc_r(mips_pkg::fn_sltu, 15, 3, 4), 32'h0000_0000);
	drain();
	report_test(2, "r-type pairs", err_start);

	err_start = errors;
	send_retry(enc_i(mips_pkg::op_addiu, 16, 0, 16'hfff0), enc_i(mips_pkg::op_slti, 17, 4, 16'hffff));
	send_retry(enc_i(mips_pkg::op_slti, 18, 3, 16'h0), enc_i(mips_pkg::op_sltiu, 19, 4, 16'hffff));
	send_retry(enc_i(mips_pkg::op_andi, 20, 3, 16'h8001), enc_i(mips_pkg::op_ori, 21, 0, 16'h8000));
	send_retry(enc_i(mips_pkg::op_xori, 22, 3, 16'h00ff), enc_i(mips_pkg::op_lui, 23, 0, 16'h1234));
	drain();
	report_test(3, "i-type immediates", err_start);

	err_start = errors;
	send_retry(enc_i(mips_pkg::op_addiu, 24, 0, 16'h7), enc_r(mips_pkg::fn_addu, 25, 24, 4));
	send_retry(enc_i(mips_pkg::op_ori, 26, 0, 16'h3), enc_r(mips_pkg::fn_subu, 27, 4, 26));
	send_retry(enc_i(mips_pkg::op_addiu, 28, 0, 16'h1), enc_i(mips_pkg::op_addiu, 28, 0, 16'h2));
	send_retry(enc_r(mips_pkg::fn_addu, 29, 28, 0), enc_r(mips_pkg::fn_addu, 0, 4, 4));
	send_retry(enc_r(mips_pkg::fn_addu, 0, 4, 4), enc_r(mips_pkg::fn_addu, 30, 0, 4));
	send_retry(enc_i(mips_pkg::op_addiu, 31, 0, 16'h9), enc_i(mips_pkg::op_lui, 1, 31, 16'h00aa));
	drain();
	report_test(4, "pairing rule", err_start);

	// EX forwarding, then register file bypass after a nop pair
	err_start = errors;
	send_retry(enc_i(mips_pkg::op_addiu, 2, 0, 16'h3), enc_i(mips_pkg::op_addiu, 3, 0, 16'h4));
	send_retry(enc_r(mips_pkg::fn_addu, 2, 2, 3), enc_r(mips_pkg::fn_addu, 4, 3, 3));
	send_retry(32'h0000_0000, 32'h0000_0000);
	send_retry(enc_r(mips_pkg::fn_addu, 5, 2, 4), enc_r(mips_pkg::fn_subu, 6, 4, 2));
	send_retry(enc_i(mips_pkg::op_addiu, 0, 0, 16'h5), enc_i(mips_pkg::op_ori, 0, 4, 16'hffff));
	send_retry(enc_r(mips_pkg::fn_addu, 7, 0, 0), enc_r(mips_pkg::fn_or, 8, 0, 4));
	drain();
	report_test(5, "forwarding and r0", err_start);

	err_start = errors;
	pend_valid = 1'b0;
	pend = '0;
	for (int i = 0; i < 400; i++)
	begin
		a = pend_valid ? pend : gen_inst();
		pend = gen_inst();
		send_pair(a, pend, taken);
		pend_valid = !taken;
	end
	drain();
	report_test(6, "random stream", err_start);

	if (u_dut.u_props.fail_count > 0)
		$display("Bound assertions failed %0d times", u_dut.u_props.fail_count);
	errors += u_dut.u_props.fail_count;
	$display("checks %0d, errors %0d", checks, errors);
	if (errors == 0)
		$display("Result: PASSED");
	else
		$display("Result: FAILED");
	$finish;
end

endmodule

// ==== dual_issue_core.f ====
+incdir+.
mips_pkg.sv
gpr_file.sv
inst_decode.sv
issue_pair_ctrl.sv
id_ex_regs.sv
alu_lane.sv
dual_issue_core.sv
dual_issue_core_props.sv
dual_issue_core_tb.sv
